// ==== verilog/rv_cfg.svh ====
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// byte address of the first fetched instruction
`define RV_START_ADDR 32'h0000_0100

// shared instruction and data RAM, in 32-bit words
`define RV_MEM_WORDS 1024

`define RV_NIBBLES 8  // slices per word for the serial adder

`endif

// ==== verilog/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // data, address and instruction words
    typedef logic [31:0] word_t;

    typedef logic [4:0] reg_idx_t;  // x0 .. x31

    typedef logic [2:0] funct3_t;

    // only the opcodes the core executes
    typedef enum logic [6:0] {
        OP_LOAD  = 7'b0000011,
        OP_IMM   = 7'b0010011,
        OP_AUIPC = 7'b0010111,
        OP_STORE = 7'b0100011,
        OP_LUI   = 7'b0110111
    } opcode_e;

    // funct3 of addi
    localparam funct3_t F3_ADDI = 3'b000;

    // funct3 of lw and sw, word access
    localparam funct3_t F3_WORD = 3'b010;

endpackage

// ==== verilog/rv_core_pkg.sv ====
`include "rv_cfg.svh"

package rv_core_pkg;

    typedef enum logic [3:0] {
        IDLE,
        FETCH,
        FETCH_WAIT,
        DECODE,
        ADD,
        MEM_READ,
        MEM_WAIT,
        MEM_WRITE,
        WRITE_BACK,
        HALT
    } ctrl_state_e;

    typedef logic [3:0] nibble_t;  // one adder slice
    typedef logic [$clog2(`RV_NIBBLES)-1:0] nib_idx_t;
    typedef logic [$clog2(`RV_MEM_WORDS)-1:0] word_addr_t;  // ram word address

endpackage

// ==== verilog/rv_mem_if.sv ====
interface rv_mem_if;
    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    logic       rd_en;  // one-cycle read strobe
    logic       wr_en;  // one-cycle write strobe
    word_addr_t addr;
    word_t      wdata;
    word_t      rdata;  // valid the cycle after rd_en

    modport master (
        output rd_en,
        output wr_en,
        output addr,
        output wdata,
        input  rdata
    );

    modport slave (
        input  rd_en,
        input  wr_en,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

// ==== verilog/rv_ram.sv ====
`include "rv_cfg.svh"

module rv_ram #(
    parameter int RAM_WORDS = `RV_MEM_WORDS
) (
    input  logic                   clk,
    input  logic                   arst_n,
    rv_mem_if.slave                mem,
    input  logic                   prog_we,
    input  rv_core_pkg::word_addr_t prog_addr,
    input  rv_isa_pkg::word_t       prog_wdata,
    input  rv_core_pkg::word_addr_t dbg_mem_addr,
    output rv_isa_pkg::word_t       dbg_mem_rdata
);
    import rv_isa_pkg::*;

    word_t words [RAM_WORDS];
    word_t rdata_q;

    // program port wins over the core port
    always_ff @(posedge clk) begin
        if (prog_we) begin
            words[prog_addr] <= prog_wdata;
        end else if (mem.wr_en) begin
            words[mem.addr] <= mem.wdata;
        end
    end

    // registered read, held until the next strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rdata_q <= '0;
        end else if (mem.rd_en) begin
            rdata_q <= words[mem.addr];
        end
    end

    assign mem.rdata = rdata_q;

    assign dbg_mem_rdata = words[dbg_mem_addr];  // async debug peek

endmodule

// ==== verilog/rv_regfile.sv ====
module rv_regfile (
    input  logic                 clk,
    input  logic                 arst_n,
    input  rv_isa_pkg::reg_idx_t rs1_idx,
    output rv_isa_pkg::word_t    rs1_data,
    input  logic                 rd_we,
    input  rv_isa_pkg::reg_idx_t rd_idx,
    input  rv_isa_pkg::word_t    rd_data,
    input  rv_isa_pkg::reg_idx_t dbg_reg_idx,
    output rv_isa_pkg::word_t    dbg_reg_data
);
    import rv_isa_pkg::*;

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && (rd_idx != '0)) begin
            regs[rd_idx] <= rd_data;  // writes to x0 dropped
        end
    end

    assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];

    assign dbg_reg_data = (dbg_reg_idx == '0) ? '0 : regs[dbg_reg_idx];

endmodule

// ==== verilog/rv_nibble_alu.sv ====
`include "rv_cfg.svh"

module rv_nibble_alu (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              alu_start,
    input  rv_isa_pkg::word_t a,
    input  rv_isa_pkg::word_t b,
    output rv_isa_pkg::word_t sum,
    output logic              alu_done
);
    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    word_t    a_q;  // operands, shifted down one slice per cycle
    word_t    b_q;
    logic     running;
    logic     carry;
    nib_idx_t idx;
    logic [4:0] slice;  // nibble sum with carry out
    nibble_t  nib;

    assign slice = {1'b0, a_q[3:0]} + {1'b0, b_q[3:0]} + {4'b0, carry};
    assign nib   = slice[3:0];

    // last slice is being added this cycle
    assign alu_done = running && (idx == nib_idx_t'(`RV_NIBBLES - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            running <= 1'b0;
            idx     <= '0;
            carry   <= 1'b0;
        end else if (alu_start) begin
            running <= 1'b1;
            idx     <= '0;
            carry   <= 1'b0;
        end else if (running) begin
            carry <= slice[4];
            idx   <= idx + 1'b1;
            if (alu_done) begin
                running <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alu_start) begin
            a_q <= a;
            b_q <= b;
        end else if (running) begin
            a_q <= a_q >> $bits(nibble_t);
            b_q <= b_q >> $bits(nibble_t);
            sum <= {nib, sum[$bits(word_t)-1:$bits(nibble_t)]};  // fill from the top
        end
    end

endmodule

// ==== verilog/rv_control.sv ====
`include "rv_cfg.svh"

module rv_control (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 start,
    rv_mem_if.master             mem,
    output rv_isa_pkg::reg_idx_t rs1_idx,
    input  rv_isa_pkg::word_t    rs1_data,
    output logic                 rd_we,
    output rv_isa_pkg::reg_idx_t rd_idx,
    output rv_isa_pkg::word_t    rd_data,
    output logic                 alu_start,
    output rv_isa_pkg::word_t    alu_a,
    output rv_isa_pkg::word_t    alu_b,
    input  rv_isa_pkg::word_t    alu_sum,
    input  logic                 alu_done,
    output logic                 busy,
    output logic                 done,
    output logic                 trap,
    output rv_isa_pkg::word_t    pc
);
    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    ctrl_state_e state;
    word_t       ir;
    opcode_e     opcode;
    word_t       i_imm;
    word_t       s_imm;
    word_t       u_imm;
    logic        legal;

    assign opcode = opcode_e'(ir[6:0]);

    // immediates, sign extended
    assign i_imm = {{20{ir[31]}}, ir[31:20]};
    assign s_imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
    assign u_imm = {ir[31:12], 12'b0};

    // zero word falls into default too, split off in DECODE
    always_comb begin
        case (opcode)
            OP_IMM:            legal = (ir[14:12] == F3_ADDI);
            OP_LOAD, OP_STORE: legal = (ir[14:12] == F3_WORD);
            OP_LUI, OP_AUIPC:  legal = 1'b1;
            default:           legal = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == FETCH_WAIT) begin
            ir <= mem.rdata;  // fetched word arrives here
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
            pc    <= `RV_START_ADDR;
            done  <= 1'b0;
            trap  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE, HALT: begin
                    if (start) begin
                        state <= FETCH;
                        pc    <= `RV_START_ADDR;
                        trap  <= 1'b0;
                    end
                end
                FETCH:      state <= FETCH_WAIT;
                FETCH_WAIT: state <= DECODE;
                DECODE: begin
                    if (ir == '0) begin
                        state <= HALT;
                        done  <= 1'b1;
                    end else if (!legal) begin
                        state <= HALT;
                        trap  <= 1'b1;  // held until the next start
                    end else if (opcode == OP_LUI) begin
                        state <= WRITE_BACK;  // no add needed
                    end else begin
                        state <= ADD;
                    end
                end
                ADD: begin
                    if (alu_done) begin
                        case (opcode)
                            OP_LOAD:  state <= MEM_READ;
                            OP_STORE: state <= MEM_WRITE;
                            default:  state <= WRITE_BACK;
                        endcase
                    end
                end
                MEM_READ: state <= MEM_WAIT;
                MEM_WAIT: state <= WRITE_BACK;
                MEM_WRITE, WRITE_BACK: begin
                    state <= FETCH;
                    pc    <= pc + 32'd4;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_comb begin
        mem.rd_en = (state == FETCH) || (state == MEM_READ);
        mem.wr_en = (state == MEM_WRITE);
        // effective address comes from the adder
        mem.addr  = (state == FETCH) ? word_addr_t'(pc[31:2]) : word_addr_t'(alu_sum[31:2]);
        mem.wdata = rs1_data;

        // second read cycle for sw picks rs2
        rs1_idx = (state == MEM_WRITE) ? ir[24:20] : ir[19:15];

        alu_start = (state == DECODE) && legal && (opcode != OP_LUI);
        alu_a     = (opcode == OP_AUIPC) ? pc : rs1_data;
        case (opcode)
            OP_STORE: alu_b = s_imm;
            OP_AUIPC: alu_b = u_imm;
            default:  alu_b = i_imm;
        endcase

        rd_we  = (state == WRITE_BACK);
        rd_idx = ir[11:7];
        case (opcode)
            OP_LOAD: rd_data = mem.rdata;  // still held from MEM_READ
            OP_LUI:  rd_data = u_imm;
            default: rd_data = alu_sum;
        endcase

        busy = (state != IDLE) && (state != HALT);
    end

endmodule

// ==== verilog/rv_nibble_core.sv ====
module rv_nibble_core (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    start,
    input  logic                    prog_we,
    input  rv_core_pkg::word_addr_t prog_addr,
    input  rv_isa_pkg::word_t       prog_wdata,
    input  rv_isa_pkg::reg_idx_t    dbg_reg_idx,
    output rv_isa_pkg::word_t       dbg_reg_data,
    input  rv_core_pkg::word_addr_t dbg_mem_addr,
    output rv_isa_pkg::word_t       dbg_mem_rdata,
    output logic                    busy,
    output logic                    done,
    output logic                    trap,
    output rv_isa_pkg::word_t       pc
);
    import rv_isa_pkg::*;

    reg_idx_t rs1_idx;
    word_t    rs1_data;
    logic     rd_we;
    reg_idx_t rd_idx;
    word_t    rd_data;
    logic     alu_start;
    word_t    alu_a;
    word_t    alu_b;
    word_t    alu_sum;
    logic     alu_done;

    rv_mem_if mem_if ();  // controller to ram

    rv_control control_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (start),
        .mem       (mem_if.master),
        .rs1_idx   (rs1_idx),
        .rs1_data  (rs1_data),
        .rd_we     (rd_we),
        .rd_idx    (rd_idx),
        .rd_data   (rd_data),
        .alu_start (alu_start),
        .alu_a     (alu_a),
        .alu_b     (alu_b),
        .alu_sum   (alu_sum),
        .alu_done  (alu_done),
        .busy      (busy),
        .done      (done),
        .trap      (trap),
        .pc        (pc)
    );

    rv_nibble_alu alu_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .alu_start (alu_start),
        .a         (alu_a),
        .b         (alu_b),
        .sum       (alu_sum),
        .alu_done  (alu_done)
    );

    rv_regfile regfile_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .rs1_idx      (rs1_idx),
        .rs1_data     (rs1_data),
        .rd_we        (rd_we),
        .rd_idx       (rd_idx),
        .rd_data      (rd_data),
        .dbg_reg_idx  (dbg_reg_idx),
        .dbg_reg_data (dbg_reg_data)
    );

    rv_ram ram_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .mem           (mem_if.slave),
        .prog_we       (prog_we),
        .prog_addr     (prog_addr),
        .prog_wdata    (prog_wdata),
        .dbg_mem_addr  (dbg_mem_addr),
        .dbg_mem_rdata (dbg_mem_rdata)
    );

endmodule

// ==== sim/rv_core_assertions.sv ====
module rv_core_assertions (
    input logic              clk,
    input logic              arst_n,
    input logic              busy,
    input logic              done,
    input logic              trap,
    input rv_isa_pkg::word_t pc
);
    int fail_count = 0;  // read by the testbench at the end

    // no activity while reset is held
    reset_quiet: assert property (@(posedge clk) !arst_n |-> (!busy && !done && !trap))
        else begin
            $error("busy, done or trap high during reset");
            fail_count++;
        end

    done_trap_excl: assert property (@(posedge clk) disable iff (!arst_n) !(done && trap))
        else begin
            $error("done and trap high in the same cycle");
            fail_count++;
        end

    done_pulse: assert property (@(posedge clk) disable iff (!arst_n) done |=> !done)
        else begin
            $error("done held for more than one cycle");
            fail_count++;
        end

    // decode cycle is still busy
    busy_before_done: assert property (@(posedge clk) disable iff (!arst_n) done |-> $past(busy))
        else begin
            $error("done without busy in the cycle before");
            fail_count++;
        end

    pc_aligned: assert property (@(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00)
        else begin
            $error("pc not word aligned");
            fail_count++;
        end

endmodule

// ==== sim/rv_core_tb.sv ====
`include "rv_cfg.svh"

module rv_core_tb;
    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    localparam word_addr_t START_WORD = word_addr_t'(`RV_START_ADDR >> 2);
    localparam word_addr_t DATA_WORD  = word_addr_t'(32'h108 >> 2);
    localparam int         TIMEOUT    = 400;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    logic        clk;
    logic        arst_n;
    logic        start;
    logic        prog_we;
    word_addr_t  prog_addr;
    word_t       prog_wdata;
    reg_idx_t    dbg_reg_idx;
    word_t       dbg_reg_data;
    word_addr_t  dbg_mem_addr;
    word_t       dbg_mem_rdata;
    logic        busy;
    logic        done;
    logic        trap;
    word_t       pc;
    int          check_errors = 0;
    logic        saw_done;
    logic        saw_trap;
    logic [11:0] rand_imm;

    rv_nibble_core dut_i (.*);

    bind rv_nibble_core rv_core_assertions assertions_i (
        .clk (clk), .arst_n (arst_n), .busy (busy), .done (done), .trap (trap), .pc (pc)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic word_t itype_word(input logic [6:0] op, input logic [2:0] f3,
                                         input reg_idx_t rd, input reg_idx_t rs1,
                                         input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t utype_word(input logic [6:0] op, input reg_idx_t rd,
                                         input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    task automatic write_word(input word_addr_t addr, input word_t data);
        prog_we    <= 1'b1;
        prog_addr  <= addr;
        prog_wdata <= data;
        @(posedge clk);
    endtask

    task automatic run_program(input string name, output logic got_done, output logic got_trap);
        int cycles;
        prog_we <= 1'b0;
        start   <= 1'b1;
        @(posedge clk);
        start    <= 1'b0;
        got_done = 1'b0;
        got_trap = 1'b0;
        cycles   = 0;
        while (!got_done && !got_trap && cycles < TIMEOUT) begin
            @(posedge clk);
            got_done = done;
            got_trap = trap;
            cycles++;
        end
        if (!got_done && !got_trap) begin
            check_errors++;
            $display("%s: core neither halted nor trapped within %0d cycles", name, TIMEOUT);
        end
    endtask

    // setup run first since the data word sits inside the setup code
    task automatic run_case(input string name, input word_t instr);
        logic d;
        logic t;
        write_word(START_WORD,     itype_word(OPC_IMM, 3'b000, 5'd2, 5'd0, 12'd1));
        write_word(START_WORD + 1, itype_word(OPC_IMM, 3'b000, 5'd3, 5'd0, 12'h100));
        write_word(START_WORD + 2, itype_word(OPC_IMM, 3'b000, 5'd4, 5'd0, 12'h110));
        write_word(START_WORD + 3, utype_word(OPC_LUI, 5'd6, 20'hcafec));
        write_word(START_WORD + 4, itype_word(OPC_IMM, 3'b000, 5'd6, 5'd6, 12'habe));  // -0x542
        write_word(START_WORD + 5, itype_word(OPC_IMM, 3'b000, 5'd5, 5'd0, 12'd0));
        write_word(START_WORD + 6, '0);
        run_program({name, " setup"}, d, t);
        assert (d && !t) else begin
            check_errors++;
            $display("%s: setup program did not halt with done", name);
        end
        write_word(START_WORD, instr);
        write_word(START_WORD + 1, '0);
        write_word(DATA_WORD, 32'hfeff1111);
        run_program(name, saw_done, saw_trap);
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        assert (actual === expected) else begin
            check_errors++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t idx, input word_t expected);
        dbg_reg_idx <= idx;
        @(posedge clk);
        assert (saw_done && !saw_trap) else begin
            check_errors++;
            $display("%s: run ended without done or with trap", name);
        end
        check_value(name, expected, dbg_reg_data);
    endtask

    initial begin
        arst_n       <= 1'b0;
        start        <= 1'b0;
        prog_we      <= 1'b0;
        prog_addr    <= '0;
        prog_wdata   <= '0;
        dbg_reg_idx  <= '0;
        dbg_mem_addr <= '0;
        void'($urandom(67));
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);

        run_case("addi_x1", itype_word(OPC_IMM, 3'b000, 5'd5, 5'd1, 12'd123));
        check_reg("addi_x1", 5'd5, 32'd123);
        check_value("halt_pc", `RV_START_ADDR + 32'd4, pc);  // address of the zero word
        run_case("addi_x2", itype_word(OPC_IMM, 3'b000, 5'd5, 5'd2, 12'd123));
        check_reg("addi_x2", 5'd5, 32'd124);
        run_case("addi_neg", itype_word(OPC_IMM, 3'b000, 5'd5, 5'd2, 12'hffe));
        check_reg("addi_neg", 5'd5, 32'hffff_ffff);  // sign bits reach every nibble
        run_case("lw_pos", itype_word(OPC_LOAD, 3'b010, 5'd5, 5'd3, 12'd8));
        check_reg("lw_pos", 5'd5, 32'hfeff_1111);
        run_case("lw_neg", itype_word(OPC_LOAD, 3'b010, 5'd5, 5'd4, 12'hff8));
        check_reg("lw_neg", 5'd5, 32'hfeff_1111);
        // sw x6, -8(x4)
        run_case("sw_neg", {7'h7f, 5'd6, 5'd4, 3'b010, 5'h18, 7'b0100011});
        dbg_mem_addr <= DATA_WORD;
        check_reg("sw_neg x6", 5'd6, 32'hcafe_babe);
        check_value("sw_neg mem", 32'hcafe_babe, dbg_mem_rdata);
        run_case("lui", utype_word(OPC_LUI, 5'd5, 20'hfffff));
        check_reg("lui", 5'd5, 32'hffff_f000);
        run_case("auipc", utype_word(OPC_AUIPC, 5'd5, 20'hffff0));
        check_reg("auipc", 5'd5, `RV_START_ADDR - 32'h1_0000);
        run_case("x0_write", itype_word(OPC_IMM, 3'b000, 5'd0, 5'd2, 12'd5));
        check_reg("x0_write", 5'd0, 32'd0);

        run_case("branch_trap", 32'h0000_0463);  // beq x0, x0, 8
        assert (saw_trap && !saw_done) else begin
            check_errors++;
            $display("branch_trap: unsupported opcode did not trap cleanly");
        end
        for (int i = 0; i < 2; i++) begin
            rand_imm = 12'($urandom);
            run_case("addi_random", itype_word(OPC_IMM, 3'b000, 5'd5, 5'd2, rand_imm));
            check_reg("addi_random", 5'd5, 32'd1 + {{20{rand_imm[11]}}, rand_imm});
        end

        $display("check errors: %0d, assertion errors: %0d", check_errors,
                 dut_i.assertions_i.fail_count);
        if (check_errors == 0 && dut_i.assertions_i.fail_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/rv_core_pkg.sv
verilog/rv_mem_if.sv
verilog/rv_ram.sv
verilog/rv_regfile.sv
verilog/rv_nibble_alu.sv
verilog/rv_control.sv
verilog/rv_nibble_core.sv
sim/rv_core_assertions.sv
sim/rv_core_tb.sv

// ==== Bender.yml ====
package:
  name: rv_nibble_core

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rv_isa_pkg.sv
      - verilog/rv_core_pkg.sv
      - verilog/rv_mem_if.sv
      - verilog/rv_ram.sv
      - verilog/rv_regfile.sv
      - verilog/rv_nibble_alu.sv
      - verilog/rv_control.sv
      - verilog/rv_nibble_core.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/rv_core_assertions.sv
      - sim/rv_core_tb.sv
